/* sim.f */
+incdir+common
common/fb_pkg.sv
framebuffer/fb_mem.sv
framebuffer/fb_axil_write.sv
design/display_timing.sv
design/line_scaler.sv
design/pixel_output.sv
design/fb_display_top.sv
tests/tb_clock.sv
tests/fb_display_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := fb_display_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/fb_display_tb.sv */
// testbench for the scaled framebuffer display
// axi driver tasks, framebuffer and palette reference model, directed tests, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module fb_display_tb;

    localparam int LINE_CLKS = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int FRAME_LINES = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int FRAME_CLKS = LINE_CLKS * FRAME_LINES;
    localparam int FB_WORDS = `FB_WIDTH * `FB_HEIGHT;
    localparam int TEST_FRAMES = 9;          // at most two per frame test, plus margin
    localparam int WRITE_CLKS = 8;           // upper bound for one host write
    localparam int TEST_WRITES = FB_WORDS + 64;
    localparam int TIMEOUT_CLKS = TEST_FRAMES * FRAME_CLKS + TEST_WRITES * WRITE_CLKS + 20000;
    localparam int HANDSHAKE_LIMIT = 100;
    localparam logic [31:0] PAL_BASE = 32'h1 << `PAL_SEL_BIT;

    logic clk_sys;
    logic rst_n;
    logic awvalid;
    logic awready;
    logic [31:0] awaddr;
    logic wvalid;
    logic wready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    logic [31:0] araddr;
    logic rvalid;
    logic rready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic dvi_hsync;
    logic dvi_vsync;
    logic dvi_de;
    logic [3:0] dvi_r;
    logic [3:0] dvi_g;
    logic [3:0] dvi_b;

    // reference model of what the host wrote
    logic [3:0] ref_fb [FB_WORDS];
    logic [11:0] ref_pal [16];
    logic [31:0] lcg_state = 32'he128_a71e;
    int errors = 0;

    tb_clock u_tb_clock (.clk_sys, .rst_n);

    fb_display_top u_fb_display_top (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run();
        errors++;
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        fail_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: expected 0x%0h, got 0x%0h", $time, name,
                     expected, actual);
            fail_run();
        end
    endtask

    task automatic send_aw(input logic [31:0] addr);
        int n;
        n = 0;
        @(posedge clk_sys);
        awvalid <= 1'b1;
        awaddr <= addr;
        @(negedge clk_sys);
        while (!awready) begin
            n++;
            if (n > HANDSHAKE_LIMIT) abort_run("awready never rose for a write address");
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        awvalid <= 1'b0;                     // transfer on this edge
    endtask

    task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
        int n;
        n = 0;
        @(posedge clk_sys);
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
        @(negedge clk_sys);
        while (!wready) begin
            n++;
            if (n > HANDSHAKE_LIMIT) abort_run("wready never rose for write data");
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        wvalid <= 1'b0;
    endtask

    // hold bready low for hold clocks once bvalid shows
    task automatic wait_b(input int hold, output logic [1:0] resp);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (!bvalid) begin
            n++;
            if (n > HANDSHAKE_LIMIT) abort_run("no write response from the DUT");
            @(negedge clk_sys);
        end
        repeat (hold) begin
            @(negedge clk_sys);
            check_value("bvalid", 1, bvalid);       // held until accepted
            check_value("awready", 0, awready);     // no new write meanwhile
            check_value("wready", 0, wready);
        end
        resp = bresp;
        @(posedge clk_sys);
        bready <= 1'b1;
        @(posedge clk_sys);
        bready <= 1'b0;
        @(negedge clk_sys);
        check_value("bvalid", 0, bvalid);
    endtask

    // order 1 aw first, 2 w first, else both together
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int order, input int hold,
                              output logic [1:0] resp);
        case (order)
            1: begin
                send_aw(addr);
                send_w(data, strb);
            end
            2: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        wait_b(hold, resp);
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        n = 0;
        @(posedge clk_sys);
        arvalid <= 1'b1;
        araddr <= addr;
        @(negedge clk_sys);
        while (!arready) begin
            n++;
            if (n > HANDSHAKE_LIMIT) abort_run("arready never rose for a read");
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk_sys);
        while (!rvalid) begin
            n++;
            if (n > HANDSHAKE_LIMIT) abort_run("no read response from the DUT");
            @(negedge clk_sys);
        end
        data = rdata;
        resp = rresp;
        check_value("arready", 0, arready);  // response still pending
        @(posedge clk_sys);
        rready <= 1'b1;
        @(posedge clk_sys);
        rready <= 1'b0;
        @(negedge clk_sys);
        check_value("rvalid", 0, rvalid);
        check_value("arready", 1, arready);
    endtask

    task automatic write_pixel(input int idx, input logic [3:0] val, input int order,
                               input int hold);
        logic [1:0] resp;
        axil_write(32'(idx) << 2, {28'h0, val}, 4'hf, order, hold, resp);
        check_value("bresp", fb_pkg::resp_ok, resp);
        ref_fb[idx] = val;
    endtask

    task automatic write_palette(input int idx, input logic [11:0] colr, input int order);
        logic [1:0] resp;
        axil_write(PAL_BASE | (32'(idx) << 2), {20'h0, colr}, 4'hf, order, 0, resp);
        check_value("bresp", fb_pkg::resp_ok, resp);
        ref_pal[idx] = colr;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        prev = 1'b0;
        @(negedge clk_sys);
        while (!(prev && !dvi_vsync)) begin
            prev = dvi_vsync;
            @(negedge clk_sys);
        end
    endtask

    // one frame, top 12 lines and bottom 4 against the model, blanking black
    task automatic check_image();
        int x;
        int y;
        logic [11:0] colour;
        logic [11:0] expected;
        x = 0;
        y = 0;
        wait_vsync_fall();
        while (y < `V_ACTIVE) begin
            @(negedge clk_sys);
            colour = {dvi_r, dvi_g, dvi_b};
            if (!dvi_de) begin
                check_value("dvi colour in blanking", 0, colour);
            end else begin
                if (y < 12 || y >= `V_ACTIVE - 4) begin
                    expected = ref_pal[ref_fb[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
                    check_value($sformatf("dvi colour (%0d,%0d)", x, y), expected, colour);
                end
                x++;
                if (x == `H_ACTIVE) begin
                    x = 0;
                    y++;
                end
            end
        end
    endtask

    task automatic check_idle_outputs();
        check_value("dvi_de", 0, dvi_de);
        check_value("dvi_hsync", 1, dvi_hsync);
        check_value("dvi_vsync", 1, dvi_vsync);
        check_value("dvi colour", 0, {dvi_r, dvi_g, dvi_b});
        check_value("bvalid", 0, bvalid);
        check_value("rvalid", 0, rvalid);
        check_value("awready", 1, awready);
        check_value("wready", 1, wready);
        check_value("arready", 1, arready);
    endtask

    task automatic verify_reset_state();
        @(negedge clk_sys);                  // inside reset
        check_idle_outputs();
        while (!rst_n) @(negedge clk_sys);
        check_idle_outputs();                // first clock out of reset
    endtask

    task automatic measure_display_timing();
        int clks;
        int last_fall;
        int lines;
        int hs_low;
        int vs_low;
        int de_clks;
        int de_lines;
        logic hs_prev;
        logic vs_prev;
        logic done;
        wait_vsync_fall();
        clks = 0;
        last_fall = -1;
        lines = 0;
        hs_low = 0;
        vs_low = 1;                          // the falling sample itself
        de_clks = 0;
        de_lines = 0;
        done = 1'b0;
        hs_prev = dvi_hsync;
        vs_prev = dvi_vsync;
        while (!done) begin
            @(negedge clk_sys);
            clks++;
            if (hs_prev && !dvi_hsync) begin
                if (last_fall >= 0) check_value("hsync period", LINE_CLKS, clks - last_fall);
                last_fall = clks;
                lines++;
                if (de_clks != 0) begin      // previous line was active
                    check_value("de clocks per line", `H_ACTIVE, de_clks);
                    de_lines++;
                end
                de_clks = 0;
            end
            if (!hs_prev && dvi_hsync) begin
                check_value("hsync low width", `H_SYNC, hs_low);
                hs_low = 0;
            end
            if (!vs_prev && dvi_vsync) check_value("vsync low clocks", `V_SYNC * LINE_CLKS, vs_low);
            if (!dvi_hsync) hs_low++;
            if (!dvi_vsync) vs_low++;
            if (dvi_de) de_clks++;
            if (vs_prev && !dvi_vsync) done = 1'b1;  // next frame begins
            hs_prev = dvi_hsync;
            vs_prev = dvi_vsync;
        end
        check_value("frame clocks", FRAME_CLKS, clks);
        check_value("lines per frame", FRAME_LINES, lines);
        check_value("active lines", `V_ACTIVE, de_lines);
    endtask

    task automatic exercise_write_handshake();
        logic [1:0] resp;
        logic [31:0] data;
        write_pixel(500, 4'h3, 1, 0);        // aw before w
        write_pixel(501, 4'h4, 2, 0);        // w before aw
        write_palette(5, 12'habc, 0);        // both together
        write_pixel(502, 4'h5, 0, 6);        // bready held low
        axil_write(32'(FB_WORDS) << 2, 32'h1, 4'hf, 0, 0, resp);
        check_value("bresp fb out of range", fb_pkg::resp_slverr, resp);
        axil_write(PAL_BASE | (32'd16 << 2), 32'h123, 4'hf, 1, 0, resp);
        check_value("bresp palette out of range", fb_pkg::resp_slverr, resp);
        axil_read(32'h0, data, resp);
        check_value("rresp", fb_pkg::resp_slverr, resp);
        check_value("rdata", 0, data);
    endtask

    task automatic load_and_check_image();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            write_palette(i, r[31:20], 0);
        end
        for (int row = 0; row < `FB_HEIGHT; row++) begin
            for (int col = 0; col < `FB_WIDTH; col++) begin
                if (row < 3 || row == `FB_HEIGHT - 1) begin
                    r = lcg_next();
                    write_pixel(row * `FB_WIDTH + col, r[27:24], 0, 0);
                end else begin
                    write_pixel(row * `FB_WIDTH + col, 4'h0, 0, 0);
                end
            end
        end
        check_image();
    endtask

    task automatic update_during_video();
        int word;
        logic [3:0] new_idx;
        word = `FB_WIDTH + 10;               // block at x 40..43, y 4..7
        new_idx = ref_fb[word] ^ 4'h8;
        @(negedge clk_sys);
        while (!dvi_de) @(negedge clk_sys);
        write_palette(new_idx, ~ref_pal[new_idx], 0);
        write_pixel(word, new_idx, 0, 0);
        check_image();
    endtask

    task automatic confirm_rejected_writes();
        logic [1:0] resp;
        axil_write(32'(FB_WORDS + 7) << 2, 32'h9, 4'hf, 0, 0, resp);
        check_value("bresp fb out of range", fb_pkg::resp_slverr, resp);
        axil_write(PAL_BASE | (32'd16 << 2), 32'hfff, 4'hf, 2, 0, resp);
        check_value("bresp palette out of range", fb_pkg::resp_slverr, resp);
        axil_write(32'h1 << (`PAL_SEL_BIT + 1), 32'h7, 4'hf, 0, 0, resp);  // above palette
        check_value("bresp unmapped", fb_pkg::resp_slverr, resp);
        // lane 0 off, acknowledged but ignored
        axil_write(32'h0, {28'h0, ~ref_fb[0]}, 4'b1110, 0, 0, resp);
        check_value("bresp strobe off pixel", fb_pkg::resp_ok, resp);
        axil_write(PAL_BASE, {20'h0, ~ref_pal[0]}, 4'b1110, 1, 0, resp);
        check_value("bresp strobe off palette", fb_pkg::resp_ok, resp);
        check_image();
    endtask

    // watchdog, sized for every frame wait plus the full framebuffer load
    initial begin
        repeat (TIMEOUT_CLKS) @(posedge clk_sys);
        abort_run($sformatf("timeout, tests did not finish within %0d clocks", TIMEOUT_CLKS));
    end

    initial begin
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        for (int i = 0; i < FB_WORDS; i++) ref_fb[i] = '0;   // memories start blank
        for (int i = 0; i < 16; i++) ref_pal[i] = '0;
        verify_reset_state();
        measure_display_timing();
        exercise_write_handshake();
        load_and_check_image();
        update_during_video();
        confirm_rejected_writes();
        if (errors == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// testbench clock and reset source
// 10 ns clock, active-low reset held for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period = 5,    // 10 ns period
    parameter int reset_cycles = 10
) (
    output logic clk_sys,
    output logic rst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #half_period clk_sys = !clk_sys;
    end

    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;                        // falling edge fires the async resets
        repeat (reset_cycles) @(posedge clk_sys);
        rst_n <= 1'b1;                          // release on a rising edge
    end

endmodule

`default_nettype wire

/* design/fb_display_top.sv */
// scaled framebuffer display top level
// axi write slave, framebuffer and palette memories, timing, scaler, output stage
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module fb_display_top (
    input  wire logic        clk_sys,
    input  wire logic        rst_n,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [31:0] awaddr,
    input  wire logic        wvalid,
    output logic             wready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    output logic             bvalid,
    input  wire logic        bready,
    output logic [1:0]       bresp,
    input  wire logic        arvalid,
    output logic             arready,
    input  wire logic [31:0] araddr,
    output logic             rvalid,
    input  wire logic        rready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             dvi_hsync,
    output logic             dvi_vsync,
    output logic             dvi_de,
    output logic [3:0]       dvi_r,
    output logic [3:0]       dvi_g,
    output logic [3:0]       dvi_b
);

    // host write side
    logic fb_we;
    fb_pkg::fb_addr_t fb_waddr;
    fb_pkg::cidx_t fb_wdata;
    logic pal_we;
    fb_pkg::pal_addr_t pal_waddr;
    fb_pkg::colr_t pal_wdata;

    // display side
    fb_pkg::fb_addr_t fb_raddr;
    fb_pkg::cidx_t fb_rdata;
    fb_pkg::coord_t sx;
    fb_pkg::coord_t sy;
    logic hsync;
    logic vsync;
    logic de;
    logic line_start;
    logic frame_start;
    fb_pkg::cidx_t pix_cidx;
    fb_pkg::colr_t pix_colr;

    fb_axil_write u_fb_axil_write (
        .clk_sys, .rst_n,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .fb_we, .fb_waddr, .fb_wdata,
        .pal_we, .pal_waddr, .pal_wdata
    );

    fb_mem #(
        .word_t(fb_pkg::cidx_t),
        .depth(`FB_WIDTH * `FB_HEIGHT)
    ) u_fb_mem (
        .clk_sys,
        .we(fb_we), .waddr(fb_waddr), .wdata(fb_wdata),
        .raddr(fb_raddr), .rdata(fb_rdata)
    );

    // palette, read address is the scaled pixel index
    fb_mem #(
        .word_t(fb_pkg::colr_t),
        .depth(2 ** $bits(fb_pkg::pal_addr_t))
    ) u_pal_mem (
        .clk_sys,
        .we(pal_we), .waddr(pal_waddr), .wdata(pal_wdata),
        .raddr(pix_cidx), .rdata(pix_colr)
    );

    display_timing u_display_timing (
        .clk_sys, .rst_n,
        .sx, .sy, .hsync, .vsync, .de, .line_start, .frame_start
    );

    line_scaler u_line_scaler (
        .clk_sys, .rst_n,
        .sx, .sy, .line_start, .frame_start,
        .fb_raddr, .fb_rdata, .pix_cidx
    );

    pixel_output u_pixel_output (
        .clk_sys, .rst_n,
        .sx, .sy, .hsync, .vsync, .de, .pix_colr,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

endmodule

`default_nettype wire

/* design/pixel_output.sv */
// output stage, syncs and enable delayed to meet palette colour
// blanking outside painted area, registered dvi outputs
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module pixel_output (
    input  wire logic           clk_sys,
    input  wire logic           rst_n,
    input  wire fb_pkg::coord_t sx,
    input  wire fb_pkg::coord_t sy,
    input  wire logic           hsync,
    input  wire logic           vsync,
    input  wire logic           de,
    input  wire fb_pkg::colr_t  pix_colr,
    output logic                dvi_hsync,
    output logic                dvi_vsync,
    output logic                dvi_de,
    output logic [3:0]          dvi_r,
    output logic [3:0]          dvi_g,
    output logic [3:0]          dvi_b
);

    localparam int DLY = `PIPE_LAT - 1;  // line buffer read + palette read

    logic paint;
    logic [DLY-1:0] hs_d;
    logic [DLY-1:0] vs_d;
    logic [DLY-1:0] de_d;
    logic [DLY-1:0] paint_d;
    fb_pkg::colr_t colr;

    assign paint = sx >= 0 && sx < `FB_WIDTH * `FB_SCALE
                   && sy >= 0 && sy < `FB_HEIGHT * `FB_SCALE;
    assign colr = (de_d[DLY-1] && paint_d[DLY-1]) ? pix_colr : '0;  // black otherwise

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_d <= '1;
            vs_d <= '1;
            de_d <= '0;
            paint_d <= '0;
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de <= 1'b0;
            {dvi_r, dvi_g, dvi_b} <= '0;
        end else begin
            hs_d <= {hs_d[DLY-2:0], hsync};
            vs_d <= {vs_d[DLY-2:0], vsync};
            de_d <= {de_d[DLY-2:0], de};
            paint_d <= {paint_d[DLY-2:0], paint};
            dvi_hsync <= hs_d[DLY-1];
            dvi_vsync <= vs_d[DLY-1];
            dvi_de <= de_d[DLY-1];
            {dvi_r, dvi_g, dvi_b} <= colr;
        end
    end

endmodule

`default_nettype wire

/* design/line_scaler.sv */
// row fetch from framebuffer into a ping-pong line buffer
// replays each row for FB_SCALE lines, each index for FB_SCALE clocks
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module line_scaler (
    input  wire logic           clk_sys,
    input  wire logic           rst_n,
    input  wire fb_pkg::coord_t sx,
    input  wire fb_pkg::coord_t sy,
    input  wire logic           line_start,
    input  wire logic           frame_start,
    output fb_pkg::fb_addr_t    fb_raddr,
    input  wire fb_pkg::cidx_t  fb_rdata,
    output fb_pkg::cidx_t       pix_cidx
);

    localparam int XW = $clog2(`FB_WIDTH);
    localparam int LCW = $clog2(`FB_SCALE);
    localparam int SCALED_W = `FB_WIDTH * `FB_SCALE;
    localparam int SCALED_H = `FB_HEIGHT * `FB_SCALE;
    localparam logic [XW-1:0] X_LAST = XW'(`FB_WIDTH - 1);
    localparam logic [LCW-1:0] L_LAST = LCW'(`FB_SCALE - 1);

    logic [LCW-1:0] lcnt;          // line within current framebuffer row
    logic [LCW-1:0] lcnt_next;
    logic fetch_go;                // first read of a row, on line_start
    logic fetching;                // rest of the row
    logic rd_en;
    logic swap;                    // first line of a new row
    logic [XW-1:0] fetch_x;        // fetch column
    logic [XW-1:0] wr_x;           // column of returning data
    logic wr_en;
    logic disp_bank;               // bank being replayed, other one fills
    fb_pkg::fb_addr_t row_base;    // word address of next row to fetch
    logic [XW-1:0] rd_x;           // sx / FB_SCALE
    logic [LCW-1:0] sub;           // sub-pixel count
    logic in_area;

    fb_pkg::cidx_t lbuf [2][`FB_WIDTH];

    // line -1 primes row 0, later the last line of each row fetches the next
    assign lcnt_next = (sy == -1) ? L_LAST : ((lcnt == L_LAST) ? '0 : lcnt + 1'b1);
    assign fetch_go = line_start && sy >= -1 && sy < SCALED_H - 1 && lcnt_next == L_LAST;
    assign swap = line_start && sy >= 0 && sy < SCALED_H && lcnt_next == '0;
    assign rd_en = fetch_go || fetching;
    assign fb_raddr = row_base + fb_pkg::fb_addr_t'(fetch_x);
    assign in_area = sx >= 0 && sx < SCALED_W && sy >= 0 && sy < SCALED_H;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lcnt <= '0;
            disp_bank <= 1'b0;
            fetching <= 1'b0;
            fetch_x <= '0;
            row_base <= '0;
            wr_en <= 1'b0;
            rd_x <= '0;
            sub <= '0;
        end else begin
            if (line_start) lcnt <= lcnt_next;
            if (swap) disp_bank <= !disp_bank;
            if (rd_en) begin
                if (fetch_x == X_LAST) begin  // 160 reads done
                    fetching <= 1'b0;
                    fetch_x <= '0;
                end else begin
                    fetching <= 1'b1;
                    fetch_x <= fetch_x + 1'b1;
                end
            end
            if (frame_start) begin
                row_base <= '0;
            end else if (rd_en && fetch_x == X_LAST) begin
                row_base <= row_base + fb_pkg::fb_addr_t'(`FB_WIDTH);
            end
            wr_en <= rd_en;  // matches memory read latency
            // horizontal scaling
            if (sx < 0) begin
                rd_x <= '0;
                sub <= '0;
            end else if (sub == L_LAST) begin
                sub <= '0;
                rd_x <= (rd_x == X_LAST) ? '0 : rd_x + 1'b1;  // wrap, stay in range
            end else begin
                sub <= sub + 1'b1;
            end
        end
    end

    // line buffer write and registered replay
    always_ff @(posedge clk_sys) begin
        wr_x <= fetch_x;
        if (wr_en) lbuf[!disp_bank][wr_x] <= fb_rdata;
        pix_cidx <= in_area ? lbuf[disp_bank][rd_x] : '0;  // index 0 outside image
    end

endmodule

`default_nettype wire

/* design/display_timing.sv */
// 640x480 display timing with signed screen coordinates
// blanking before the active area, negative syncs, line and frame start flags
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module display_timing (
    input  wire logic      clk_sys,
    input  wire logic      rst_n,
    output fb_pkg::coord_t sx,
    output fb_pkg::coord_t sy,
    output logic           hsync,
    output logic           vsync,
    output logic           de,
    output logic           line_start,
    output logic           frame_start
);

    // horizontal: blanking from -160, active 0..639
    localparam fb_pkg::coord_t H_STA = fb_pkg::coord_t'(-(`H_FP + `H_SYNC + `H_BP));
    localparam fb_pkg::coord_t HS_STA = fb_pkg::coord_t'(H_STA + `H_FP);
    localparam fb_pkg::coord_t HS_END = fb_pkg::coord_t'(HS_STA + `H_SYNC);
    localparam fb_pkg::coord_t HA_END = fb_pkg::coord_t'(`H_ACTIVE - 1);

    // vertical: blanking from -45, active 0..479
    localparam fb_pkg::coord_t V_STA = fb_pkg::coord_t'(-(`V_FP + `V_SYNC + `V_BP));
    localparam fb_pkg::coord_t VS_STA = fb_pkg::coord_t'(V_STA + `V_FP);
    localparam fb_pkg::coord_t VS_END = fb_pkg::coord_t'(VS_STA + `V_SYNC);
    localparam fb_pkg::coord_t VA_END = fb_pkg::coord_t'(`V_ACTIVE - 1);

    fb_pkg::coord_t sx_next;
    fb_pkg::coord_t sy_next;

    always_comb begin
        sx_next = (sx == HA_END) ? H_STA : sx + 16'sd1;
        sy_next = sy;
        if (sx == HA_END) begin
            sy_next = (sy == VA_END) ? V_STA : sy + 16'sd1;  // next line
        end
    end

    // syncs come from the next coordinates so they line up with sx and sy
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sx <= H_STA;
            sy <= V_STA;
            hsync <= 1'b1;  // inactive high
            vsync <= 1'b1;
        end else begin
            sx <= sx_next;
            sy <= sy_next;
            hsync <= !(sx_next >= HS_STA && sx_next < HS_END);
            vsync <= !(sy_next >= VS_STA && sy_next < VS_END);
        end
    end

    assign de = (sx >= 0 && sy >= 0);       // active area only
    assign line_start = (sx == H_STA);      // first blanking clock of a line
    assign frame_start = line_start && (sy == V_STA);

endmodule

`default_nettype wire

/* framebuffer/fb_axil_write.sv */
// axi4-lite slave for host writes into framebuffer and palette
// aw and w captured independently, range-checked decode, error-only read channel
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module fb_axil_write (
    input  wire logic        clk_sys,
    input  wire logic        rst_n,
    // write address
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [31:0] awaddr,
    // write data
    input  wire logic        wvalid,
    output logic             wready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    // write response
    output logic             bvalid,
    input  wire logic        bready,
    output logic [1:0]       bresp,
    // read address and data
    input  wire logic        arvalid,
    output logic             arready,
    input  wire logic [31:0] araddr,
    output logic             rvalid,
    input  wire logic        rready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    // memory write ports
    output logic             fb_we,
    output fb_pkg::fb_addr_t fb_waddr,
    output fb_pkg::cidx_t    fb_wdata,
    output logic             pal_we,
    output fb_pkg::pal_addr_t pal_waddr,
    output fb_pkg::colr_t    pal_wdata
);

    logic aw_held;                    // address captured, maybe waiting on data
    logic w_held;                     // data captured
    logic [31:2] addr_q;              // word address of held write
    fb_pkg::colr_t wdata_q;           // widest payload is a palette colour
    logic strb_q;                     // byte lane 0 enable
    logic [`PAL_SEL_BIT-3:0] widx;    // word index below the palette select bit
    logic upper_ok;
    logic fb_hit;
    logic pal_hit;
    logic do_write;

    // one outstanding write, nothing accepted while the response waits
    assign awready = !aw_held && !bvalid;
    assign wready = !w_held && !bvalid;

    assign widx = addr_q[`PAL_SEL_BIT-1:2];
    assign upper_ok = (addr_q[31:`PAL_SEL_BIT+1] == '0);  // no aliasing
    assign fb_hit = upper_ok && !addr_q[`PAL_SEL_BIT] && (widx < `FB_WIDTH * `FB_HEIGHT);
    assign pal_hit = upper_ok && addr_q[`PAL_SEL_BIT]
                     && (widx < 2 ** $bits(fb_pkg::pal_addr_t));
    assign do_write = aw_held && w_held;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            bresp <= fb_pkg::resp_ok;
            fb_we <= 1'b0;
            pal_we <= 1'b0;
        end else begin
            fb_we <= 1'b0;  // single-clock strobes
            pal_we <= 1'b0;
            if (awvalid && awready) aw_held <= 1'b1;
            if (wvalid && wready) w_held <= 1'b1;
            if (do_write) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
                bvalid <= 1'b1;
                // bad address errors, lane 0 off on a good address is a quiet no-op
                bresp <= (fb_hit || pal_hit) ? fb_pkg::resp_ok : fb_pkg::resp_slverr;
                fb_we <= fb_hit && strb_q;
                pal_we <= pal_hit && strb_q;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // held address and data, strobe targets
    always_ff @(posedge clk_sys) begin
        if (awvalid && awready) addr_q <= awaddr[31:2];
        if (wvalid && wready) begin
            wdata_q <= wdata[11:0];
            strb_q <= wstrb[0];
        end
        if (do_write) begin
            fb_waddr <= widx;
            fb_wdata <= wdata_q[3:0];  // pixel index in the low nibble
            pal_waddr <= widx[3:0];
            pal_wdata <= wdata_q;
        end
    end

    // reads always fail, memory is write-only from the host
    assign arready = !rvalid;
    assign rdata = '0;
    assign rresp = fb_pkg::resp_slverr;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* framebuffer/fb_mem.sv */
// simple dual-port memory, one write port and one registered read port
// word type is a parameter so the same block holds pixel indices or colours
`timescale 1ns/1ps
`default_nettype none

module fb_mem #(
    parameter type word_t = logic [7:0],
    parameter int depth = 256
) (
    input  wire logic                     clk_sys,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] waddr,
    input  wire word_t                    wdata,
    input  wire logic [$clog2(depth)-1:0] raddr,
    output word_t                         rdata
);

    word_t mem [depth];

    // start blank, no image file
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[waddr] <= wdata;  // host side
    end

    // display side, one clock read latency
    always_ff @(posedge clk_sys) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* common/fb_pkg.sv */
// types shared across the display subsystem
// pixel index, colour, memory addresses, screen coordinate, axi response codes
`default_nettype none

package fb_pkg;

    typedef logic [3:0] cidx_t;           // palette index stored per pixel
    typedef logic [11:0] colr_t;          // {r, g, b}, 4 bits per channel

    // memory addresses
    typedef logic [14:0] fb_addr_t;       // 19200 framebuffer words
    typedef logic [3:0] pal_addr_t;       // 16 palette entries

    // negative during blanking, 0..639 / 0..479 when active
    typedef logic signed [15:0] coord_t;

    // axi response codes
    localparam logic [1:0] resp_ok = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* common/fb_cfg.svh */
// framebuffer display configuration
// framebuffer geometry and scale, 640x480 timing, pipeline latency, host address map
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// framebuffer geometry
`define FB_WIDTH    160  // pixels per framebuffer row
`define FB_HEIGHT   120  // framebuffer rows
`define FB_SCALE    4    // each pixel shown as a 4x4 block

// horizontal timing in clocks
`define H_ACTIVE    640
`define H_FP        16
`define H_SYNC      96
`define H_BP        48

// vertical timing in lines
`define V_ACTIVE    480
`define V_FP        10
`define V_SYNC      2
`define V_BP        33

`define PIPE_LAT    3    // coordinates to registered dvi outputs
`define PAL_SEL_BIT 17   // pixel word index needs bits 16..2, palette sits above it

`endif
